/* io_tile.f */
+incdir+source
source/tile_msg_pkg.sv
source/tile_map_pkg.sv
source/fwd_decode.sv
source/stream_xbar.sv
source/cfg_slice.sv
source/scratchpad_slice.sv
source/io_tile.sv
sim/io_tile_tb.sv

/* run_sim.sh */
#!/bin/sh
# compile and simulate io_tile_tb, then look for the pass line in the output
cd "$(dirname "$0")" || exit 1

verilator --binary --assert --top-module io_tile_tb -f io_tile.f \
  || { echo "io_tile: build failed"; exit 1; }

sim_out=$(./obj_dir/Vio_tile_tb 2>&1)
printf '%s\n' "$sim_out"

printf '%s\n' "$sim_out" | grep -q "Test passed" \
  && echo "io_tile: simulation ok" \
  || { echo "io_tile: simulation FAILED"; exit 1; }

/* sim/io_tile_golden.txt */
// source op addr wdata expected, all hex
// op 0 reads and 1 writes, a source of f ends the list
0 0 000c 00000000 00000005
0 0 001c 00000000 00000000
0 0 0004 00000000 00000001
0 0 0008 00000000 00000100
1 1 1020 b1b10008 b1b10008
0 1 1000 a0a00000 a0a00000
1 1 103c b1b1000f b1b1000f
0 1 101c a0a00007 a0a00007
1 1 1030 b1b1000c b1b1000c
0 1 1008 a0a00002 a0a00002
1 0 1020 00000000 b1b10008
0 0 1000 00000000 a0a00000
1 1 103c d00d000f d00d000f
0 1 1000 c0de0000 c0de0000
1 0 103c 00000000 d00d000f
0 0 101c 00000000 a0a00007
1 0 1030 00000000 b1b1000c
0 0 1000 00000000 c0de0000
1 0 7000 00000000 00000000
0 0 1008 00000000 a0a00002
1 0 0010 00000000 00000000
0 1 0004 00000000 00000000
1 1 000c ffffffff 00000005
0 1 0008 00012344 00002344
1 0 000c 00000000 00000005
0 1 001c 000001ff 000000ff
0 0 0004 00000000 00000000
0 0 0008 00000000 00002344
0 0 001c 00000000 000000ff
f 0 0000 00000000 00000000

/* sim/io_tile_tb.sv */
`include "tile_params.svh"

module io_tile_tb;

  timeunit 1ns;
  timeprecision 1ps;

  import tile_msg_pkg::*;
  import tile_map_pkg::*;

  localparam int clk_period_lp = 100;
  localparam int settle_lp = 10;
  localparam int golden_cols_lp = 5;
  localparam int golden_depth_lp = 256;
  localparam int max_lines_lp = golden_depth_lp / golden_cols_lp;
  localparam logic [31:0] end_marker_lp = 32'hf;

  typedef logic [$clog2(golden_depth_lp)-1:0] golden_idx_t;

  logic clk_i;
  logic arst_n_i;
  logic [`TILE_NUM_SRC-1:0] fwd_valid_i;
  mem_fwd_s [`TILE_NUM_SRC-1:0] fwd_msg_i;
  logic [`TILE_NUM_SRC-1:0] fwd_ready_o;
  logic [`TILE_NUM_SRC-1:0] rev_valid_o;
  mem_rev_s [`TILE_NUM_SRC-1:0] rev_msg_o;
  logic [`TILE_NUM_SRC-1:0] rev_ready_i;
  logic freeze_o;
  logic [`TILE_ADDR_WIDTH-1:0] boot_npc_o;

  // five words per line, src op addr wdata expected
  logic [31:0] golden_mem [golden_depth_lp];
  int num_lines;
  int exp_count [`TILE_NUM_SRC];
  int resp_count [`TILE_NUM_SRC];
  bit load_done;

  // cfg outputs as the register rules predict
  logic model_freeze;
  logic [`TILE_ADDR_WIDTH-1:0] model_boot_npc;

  io_tile UUT
    (.clk_i(clk_i)
     ,.arst_n_i(arst_n_i)
     ,.fwd_valid_i(fwd_valid_i)
     ,.fwd_msg_i(fwd_msg_i)
     ,.fwd_ready_o(fwd_ready_o)
     ,.rev_valid_o(rev_valid_o)
     ,.rev_msg_o(rev_msg_o)
     ,.rev_ready_i(rev_ready_i)
     ,.freeze_o(freeze_o)
     ,.boot_npc_o(boot_npc_o)
     );

  function automatic logic [31:0] golden_field(input int line, input int col);
    return golden_mem[golden_idx_t'(line * golden_cols_lp + col)];
  endfunction

  function automatic logic [31:0] lcg_next(input logic [31:0] state);
    return state * 32'd1664525 + 32'd1013904223;
  endfunction

  task automatic end_with_failure();
    $display("Test failed");
    $fatal(1, "simulation stopped on the first error");
  endtask

  task automatic show_mismatch(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
    $display("** Error: %s = 0x%h, expected 0x%h", name, got, exp);
    end_with_failure();
  endtask

  task automatic check_rev(input string name, input mem_rev_s got, input mem_rev_s exp);
    if (got.op !== exp.op)
      show_mismatch({name, ".op"}, 32'(got.op), 32'(exp.op));
    if (got.addr !== exp.addr)
      show_mismatch({name, ".addr"}, 32'(got.addr), 32'(exp.addr));
    if (got.data !== exp.data)
      show_mismatch({name, ".data"}, 32'(got.data), 32'(exp.data));
    if (got.src_id !== exp.src_id)
      show_mismatch({name, ".src_id"}, 32'(got.src_id), 32'(exp.src_id));
  endtask

  task automatic check_cfg(input logic exp_freeze, input logic [`TILE_ADDR_WIDTH-1:0] exp_npc);
    if (freeze_o !== exp_freeze)
      show_mismatch("freeze_o", 32'(freeze_o), 32'(exp_freeze));
    if (boot_npc_o !== exp_npc)
      show_mismatch("boot_npc_o", 32'(boot_npc_o), 32'(exp_npc));
  endtask

  // one request in flight, next line only after its response
  task automatic run_source(input src_id_t src);
    mem_fwd_s req;
    mem_rev_s exp_rsp;
    logic [31:0] f_src, f_op, f_addr;
    string port_name;
    port_name = $sformatf("rev_msg_o[%0d]", src);
    for (int i = 0; i < num_lines; i++)
    begin
      f_src = golden_field(i, 0);
      if (f_src[$bits(src_id_t)-1:0] == src)
      begin
        f_op = golden_field(i, 1);
        f_addr = golden_field(i, 2);
        req.op = mem_op_e'(f_op[0]);
        req.addr = f_addr[`TILE_ADDR_WIDTH-1:0];
        req.data = golden_field(i, 3);
        req.src_id = src;
        exp_rsp.op = req.op;
        exp_rsp.addr = req.addr;
        exp_rsp.data = golden_field(i, 4);
        exp_rsp.src_id = src;

        @(negedge clk_i);
        fwd_msg_i[src] = req;
        fwd_valid_i[src] = 1'b1;
        #settle_lp;
        while (fwd_ready_o[src] !== 1'b1)
        begin
          @(negedge clk_i);
          #settle_lp;
        end
        // taken on the rising edge in between
        @(negedge clk_i);
        fwd_valid_i[src] = 1'b0;
        #settle_lp;
        while (!(rev_valid_o[src] === 1'b1 && rev_ready_i[src] === 1'b1))
        begin
          @(negedge clk_i);
          #settle_lp;
        end
        check_rev(port_name, rev_msg_o[src], exp_rsp);

        // only source 0 touches freeze and boot pc
        if (src == src_id_t'(0))
        begin
          if (req.op == e_mem_wr && req.addr[`TILE_ADDR_WIDTH-1-:4] != `TILE_SPAD_BLOCK)
          begin
            if (req.addr[11:0] == e_cfg_freeze)
              model_freeze = req.data[0];
            else if (req.addr[11:0] == e_cfg_boot_npc)
              model_boot_npc = req.data[`TILE_ADDR_WIDTH-1:0];
          end
          check_cfg(model_freeze, model_boot_npc);
        end
      end
    end
  endtask

  initial
  begin
    clk_i = 1'b0;
    forever #(clk_period_lp / 2) clk_i = ~clk_i;
  end

  // random response back-pressure
  initial
  begin
    logic [31:0] lcg_state;
    lcg_state = 32'd31;
    rev_ready_i = '1;
    @(posedge arst_n_i);
    forever
    begin
      @(negedge clk_i);
      for (int k = 0; k < `TILE_NUM_SRC; k++)
      begin
        lcg_state = lcg_next(lcg_state);
        rev_ready_i[src_id_t'(k)] = (lcg_state[25:24] != 2'b00);
      end
    end
  end

  // counts every response transfer per port
  initial
  begin
    for (int k = 0; k < `TILE_NUM_SRC; k++)
      resp_count[src_id_t'(k)] = 0;
    forever
    begin
      @(negedge clk_i);
      #settle_lp;
      for (int k = 0; k < `TILE_NUM_SRC; k++)
      begin
        if (arst_n_i && rev_valid_o[src_id_t'(k)] && rev_ready_i[src_id_t'(k)])
          resp_count[src_id_t'(k)]++;
      end
    end
  end

  initial
  begin
    wait (load_done);
    repeat (5 + num_lines * 40) @(posedge clk_i);
    $display("timeout, the requests did not all complete within %0d cycles", num_lines * 40);
    end_with_failure();
  end

  initial
  begin
    logic [31:0] f_src;
    bit count_ok;
    arst_n_i = 1'b0;
    fwd_valid_i = '0;
    fwd_msg_i = '0;
    load_done = 1'b0;
    num_lines = 0;
    model_freeze = 1'b1;
    model_boot_npc = `TILE_BOOT_NPC_RESET;
    for (int k = 0; k < `TILE_NUM_SRC; k++)
      exp_count[src_id_t'(k)] = 0;

    $readmemh("sim/io_tile_golden.txt", golden_mem);
    while (num_lines < max_lines_lp && golden_field(num_lines, 0) != end_marker_lp)
    begin
      f_src = golden_field(num_lines, 0);
      exp_count[src_id_t'(f_src)]++;
      num_lines++;
    end
    if (num_lines == 0)
    begin
      $display("the golden file holds no request lines");
      end_with_failure();
    end
    load_done = 1'b1;

    repeat (5) @(posedge clk_i);
    @(negedge clk_i);
    arst_n_i = 1'b1;
    #settle_lp;
    if (rev_valid_o !== '0 || fwd_ready_o !== '1)
    begin
      $display("handshake outputs are not idle after reset");
      end_with_failure();
    end
    check_cfg(model_freeze, model_boot_npc);

    fork
      run_source(src_id_t'(0));
      run_source(src_id_t'(1));
    join

    // late or duplicated responses would still show up here
    repeat (10) @(negedge clk_i);
    count_ok = 1'b1;
    for (int k = 0; k < `TILE_NUM_SRC; k++)
    begin
      if (resp_count[src_id_t'(k)] != exp_count[src_id_t'(k)])
      begin
        $display("port %0d returned %0d responses for %0d requests", k,
                 resp_count[src_id_t'(k)], exp_count[src_id_t'(k)]);
        count_ok = 1'b0;
      end
    end
    if (count_ok)
    begin
      $display("Test passed");
      $finish;
    end
    else
    begin
      $display("Test failed");
      $fatal(1, "response count mismatch");
    end
  end

endmodule

/* source/cfg_slice.sv */
`include "tile_params.svh"

module cfg_slice
  (input logic clk_i
   , input logic arst_n_i

   , input logic fwd_valid_i
   , input tile_msg_pkg::mem_fwd_s fwd_msg_i
   , output logic fwd_ready_o

   , output logic rev_valid_o
   , output tile_msg_pkg::mem_rev_s rev_msg_o
   , input logic rev_ready_i

   , output logic freeze_o
   , output logic [`TILE_ADDR_WIDTH-1:0] boot_npc_o
   );

  import tile_msg_pkg::*;
  import tile_map_pkg::*;

  logic freeze_r, freeze_n;
  logic [`TILE_ADDR_WIDTH-1:0] boot_npc_r, boot_npc_n;
  logic [`TILE_HIO_WIDTH-1:0] hio_mask_r, hio_mask_n;
  logic fwd_accept;
  logic is_write;
  logic [$bits(cfg_reg_e)-1:0] reg_offset;
  logic [`TILE_DATA_WIDTH-1:0] rdata;

  // one reply slot, refilled as it drains
  assign fwd_ready_o = ~rev_valid_o | rev_ready_i;
  assign fwd_accept = fwd_valid_i & fwd_ready_o;
  assign is_write = fwd_accept & (fwd_msg_i.op == e_mem_wr);
  assign reg_offset = fwd_msg_i.addr[$bits(cfg_reg_e)-1:0];

  always_comb
  begin
    freeze_n = freeze_r;
    boot_npc_n = boot_npc_r;
    hio_mask_n = hio_mask_r;
    if (is_write)
    begin
      // core id and unknown offsets drop the write
      case (reg_offset)
        e_cfg_freeze: freeze_n = fwd_msg_i.data[0];
        e_cfg_boot_npc: boot_npc_n = fwd_msg_i.data[`TILE_ADDR_WIDTH-1:0];
        e_cfg_hio_mask: hio_mask_n = fwd_msg_i.data[`TILE_HIO_WIDTH-1:0];
        default: ;
      endcase
    end

    // reply carries the value after the write
    rdata = '0;
    case (reg_offset)
      e_cfg_freeze: rdata[0] = freeze_n;
      e_cfg_boot_npc: rdata[`TILE_ADDR_WIDTH-1:0] = boot_npc_n;
      e_cfg_core_id: rdata = `TILE_CORE_ID;
      e_cfg_hio_mask: rdata[`TILE_HIO_WIDTH-1:0] = hio_mask_n;
      default: ;
    endcase
  end

  always_ff @(posedge clk_i or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      // core starts frozen
      freeze_r <= 1'b1;
      boot_npc_r <= `TILE_BOOT_NPC_RESET;
      hio_mask_r <= '0;
      rev_valid_o <= 1'b0;
    end
    else
    begin
      freeze_r <= freeze_n;
      boot_npc_r <= boot_npc_n;
      hio_mask_r <= hio_mask_n;
      if (fwd_accept)
        rev_valid_o <= 1'b1;
      else if (rev_ready_i)
        rev_valid_o <= 1'b0;
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (fwd_accept)
    begin
      rev_msg_o <= '{op: fwd_msg_i.op, addr: fwd_msg_i.addr, data: rdata,
                     src_id: fwd_msg_i.src_id};
    end
  end

  assign freeze_o = freeze_r;
  assign boot_npc_o = boot_npc_r;

  // a pending reply that is not leaving is neither dropped nor overwritten
  assert property (@(posedge clk_i) disable iff (!arst_n_i)
    rev_valid_o && !rev_ready_i |=> rev_valid_o && $stable(rev_msg_o));

endmodule

/* source/fwd_decode.sv */
`include "tile_params.svh"

module fwd_decode
  (input logic [`TILE_ADDR_WIDTH-1:0] addr_i
   , output tile_map_pkg::dev_id_e dst_o
   );

  import tile_map_pkg::*;

  // top address nibble picks the block
  localparam int block_width_lp = 4;

  logic [block_width_lp-1:0] addr_block;
  logic is_spad_fwd;

  assign addr_block = addr_i[`TILE_ADDR_WIDTH-1-:block_width_lp];
  assign is_spad_fwd = (addr_block == `TILE_SPAD_BLOCK);

  // everything outside the scratchpad block lands in cfg
  assign dst_o = is_spad_fwd ? e_dev_spad : e_dev_cfg;

endmodule

/* source/io_tile.sv */
`include "tile_params.svh"

module io_tile
  (input logic clk_i
   , input logic arst_n_i

   , input logic [`TILE_NUM_SRC-1:0] fwd_valid_i
   , input tile_msg_pkg::mem_fwd_s [`TILE_NUM_SRC-1:0] fwd_msg_i
   , output logic [`TILE_NUM_SRC-1:0] fwd_ready_o

   , output logic [`TILE_NUM_SRC-1:0] rev_valid_o
   , output tile_msg_pkg::mem_rev_s [`TILE_NUM_SRC-1:0] rev_msg_o
   , input logic [`TILE_NUM_SRC-1:0] rev_ready_i

   , output logic freeze_o
   , output logic [`TILE_ADDR_WIDTH-1:0] boot_npc_o
   );

  import tile_msg_pkg::*;
  import tile_map_pkg::*;

  // source side, {back-end, front-end}
  logic [`TILE_NUM_SRC-1:0][$bits(dev_id_e)-1:0] fwd_dst;

  // device side, {spad, cfg}
  logic [`TILE_NUM_DEV-1:0] dev_fwd_valid, dev_fwd_ready;
  mem_fwd_s [`TILE_NUM_DEV-1:0] dev_fwd_msg;
  logic [`TILE_NUM_DEV-1:0] dev_rev_valid, dev_rev_ready;
  mem_rev_s [`TILE_NUM_DEV-1:0] dev_rev_msg;
  logic [`TILE_NUM_DEV-1:0][$bits(src_id_t)-1:0] dev_rev_dst;

  for (genvar i = 0; i < `TILE_NUM_SRC; i++)
  begin : fwd_dest
    fwd_decode fwd_dec
      (.addr_i(fwd_msg_i[i].addr)
       ,.dst_o(fwd_dst[i])
       );
  end

  stream_xbar
    #(.msg_t(mem_fwd_s)
      ,.num_src_p(`TILE_NUM_SRC)
      ,.num_sink_p(`TILE_NUM_DEV)
      )
    fwd_xbar
      (.clk_i(clk_i)
       ,.arst_n_i(arst_n_i)
       ,.src_valid_i(fwd_valid_i)
       ,.src_msg_i(fwd_msg_i)
       ,.src_dst_i(fwd_dst)
       ,.src_ready_o(fwd_ready_o)
       ,.sink_valid_o(dev_fwd_valid)
       ,.sink_msg_o(dev_fwd_msg)
       ,.sink_ready_i(dev_fwd_ready)
       );

  // responses find their way home by source id
  for (genvar d = 0; d < `TILE_NUM_DEV; d++)
  begin : rev_dest
    assign dev_rev_dst[d] = dev_rev_msg[d].src_id;
  end

  stream_xbar
    #(.msg_t(mem_rev_s)
      ,.num_src_p(`TILE_NUM_DEV)
      ,.num_sink_p(`TILE_NUM_SRC)
      )
    rev_xbar
      (.clk_i(clk_i)
       ,.arst_n_i(arst_n_i)
       ,.src_valid_i(dev_rev_valid)
       ,.src_msg_i(dev_rev_msg)
       ,.src_dst_i(dev_rev_dst)
       ,.src_ready_o(dev_rev_ready)
       ,.sink_valid_o(rev_valid_o)
       ,.sink_msg_o(rev_msg_o)
       ,.sink_ready_i(rev_ready_i)
       );

  cfg_slice cfgs
    (.clk_i(clk_i)
     ,.arst_n_i(arst_n_i)
     ,.fwd_valid_i(dev_fwd_valid[e_dev_cfg])
     ,.fwd_msg_i(dev_fwd_msg[e_dev_cfg])
     ,.fwd_ready_o(dev_fwd_ready[e_dev_cfg])
     ,.rev_valid_o(dev_rev_valid[e_dev_cfg])
     ,.rev_msg_o(dev_rev_msg[e_dev_cfg])
     ,.rev_ready_i(dev_rev_ready[e_dev_cfg])
     ,.freeze_o(freeze_o)
     ,.boot_npc_o(boot_npc_o)
     );

  scratchpad_slice spad
    (.clk_i(clk_i)
     ,.arst_n_i(arst_n_i)
     ,.fwd_valid_i(dev_fwd_valid[e_dev_spad])
     ,.fwd_msg_i(dev_fwd_msg[e_dev_spad])
     ,.fwd_ready_o(dev_fwd_ready[e_dev_spad])
     ,.rev_valid_o(dev_rev_valid[e_dev_spad])
     ,.rev_msg_o(dev_rev_msg[e_dev_spad])
     ,.rev_ready_i(dev_rev_ready[e_dev_spad])
     );

endmodule

/* source/scratchpad_slice.sv */
`include "tile_params.svh"

module scratchpad_slice
  (input logic clk_i
   , input logic arst_n_i

   , input logic fwd_valid_i
   , input tile_msg_pkg::mem_fwd_s fwd_msg_i
   , output logic fwd_ready_o

   , output logic rev_valid_o
   , output tile_msg_pkg::mem_rev_s rev_msg_o
   , input logic rev_ready_i
   );

  import tile_msg_pkg::*;

  localparam int idx_width_lp = $clog2(`TILE_SPAD_ELS);

  logic [`TILE_DATA_WIDTH-1:0] mem_r [`TILE_SPAD_ELS];
  logic [idx_width_lp-1:0] word_idx;
  logic fwd_accept;
  logic is_write;
  logic [`TILE_DATA_WIDTH-1:0] rdata;

  assign fwd_ready_o = ~rev_valid_o | rev_ready_i;
  assign fwd_accept = fwd_valid_i & fwd_ready_o;
  assign is_write = fwd_msg_i.op == e_mem_wr;

  // word addressed, byte offset ignored
  assign word_idx = fwd_msg_i.addr[2+:idx_width_lp];

  // write returns the new word
  assign rdata = is_write ? fwd_msg_i.data : mem_r[word_idx];

  always_ff @(posedge clk_i or negedge arst_n_i)
  begin
    if (!arst_n_i)
      rev_valid_o <= 1'b0;
    else if (fwd_accept)
      rev_valid_o <= 1'b1;
    else if (rev_ready_i)
      rev_valid_o <= 1'b0;
  end

  always_ff @(posedge clk_i)
  begin
    if (fwd_accept)
    begin
      if (is_write)
        mem_r[word_idx] <= fwd_msg_i.data;
      rev_msg_o <= '{op: fwd_msg_i.op, addr: fwd_msg_i.addr, data: rdata,
                     src_id: fwd_msg_i.src_id};
    end
  end

endmodule

/* source/stream_xbar.sv */
module stream_xbar
  #(parameter type msg_t = logic
    , parameter int num_src_p = 2
    , parameter int num_sink_p = 2
    , localparam int sink_id_width_lp = (num_sink_p > 1) ? $clog2(num_sink_p) : 1
    )
  (input logic clk_i
   , input logic arst_n_i

   , input logic [num_src_p-1:0] src_valid_i
   , input msg_t [num_src_p-1:0] src_msg_i
   , input logic [num_src_p-1:0][sink_id_width_lp-1:0] src_dst_i
   , output logic [num_src_p-1:0] src_ready_o

   , output logic [num_sink_p-1:0] sink_valid_o
   , output msg_t [num_sink_p-1:0] sink_msg_o
   , input logic [num_sink_p-1:0] sink_ready_i
   );

  localparam int src_id_width_lp = (num_src_p > 1) ? $clog2(num_src_p) : 1;

  logic [num_sink_p-1:0] sink_free;
  logic [num_sink_p-1:0] sink_any;
  logic [num_sink_p-1:0] sink_load;
  logic [num_sink_p-1:0][src_id_width_lp-1:0] sink_win;
  logic [num_sink_p-1:0][src_id_width_lp-1:0] rr_ptr_r;
  logic [num_src_p-1:0][num_sink_p-1:0] src_grant;

  // per-sink round robin, search starts at the pointer
  always_comb
  begin
    int idx;
    for (int k = 0; k < num_sink_p; k++)
    begin
      // register empty or draining this cycle
      sink_free[k] = ~sink_valid_o[k] | sink_ready_i[k];
      sink_any[k] = 1'b0;
      sink_win[k] = '0;
      for (int i = 0; i < num_src_p; i++)
      begin
        idx = (int'(rr_ptr_r[k]) + i) % num_src_p;
        if (!sink_any[k] && src_valid_i[idx] && (int'(src_dst_i[idx]) == k))
        begin
          sink_any[k] = 1'b1;
          sink_win[k] = src_id_width_lp'(idx);
        end
      end
      sink_load[k] = sink_any[k] & sink_free[k];
    end
  end

  // ready follows the grant of the sink a source points at
  always_comb
  begin
    for (int s = 0; s < num_src_p; s++)
    begin
      src_ready_o[s] = 1'b0;
      for (int k = 0; k < num_sink_p; k++)
      begin
        src_grant[s][k] = sink_load[k] & (int'(sink_win[k]) == s);
        if (int'(src_dst_i[s]) == k)
        begin
          // idle sources see ready when nobody else claims the sink
          src_ready_o[s] = sink_free[k] & (~sink_any[k] | (int'(sink_win[k]) == s));
        end
      end
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      sink_valid_o <= '0;
      rr_ptr_r <= '0;
    end
    else
    begin
      for (int k = 0; k < num_sink_p; k++)
      begin
        if (sink_load[k])
        begin
          sink_valid_o[k] <= 1'b1;
          // winner drops to lowest priority
          rr_ptr_r[k] <= src_id_width_lp'((int'(sink_win[k]) + 1) % num_src_p);
        end
        else if (sink_ready_i[k])
        begin
          sink_valid_o[k] <= 1'b0;
        end
      end
    end
  end

  always_ff @(posedge clk_i)
  begin
    for (int k = 0; k < num_sink_p; k++)
    begin
      if (sink_load[k])
      begin
        sink_msg_o[k] <= src_msg_i[sink_win[k]];
      end
    end
  end

  for (genvar k = 0; k < num_sink_p; k++)
  begin : sink_chk
    // stalled output holds until taken
    assert property (@(posedge clk_i) disable iff (!arst_n_i)
      sink_valid_o[k] && !sink_ready_i[k] |=> sink_valid_o[k] && $stable(sink_msg_o[k]));
  end

  for (genvar s = 0; s < num_src_p; s++)
  begin : src_chk
    // a source transfer lands in exactly one sink, and only a transfer does
    assert property (@(posedge clk_i) disable iff (!arst_n_i)
      $onehot0(src_grant[s])
      && ((src_valid_i[s] && src_ready_o[s]) == (src_grant[s] != '0)));
  end

endmodule

/* source/tile_map_pkg.sv */
`include "tile_params.svh"

package tile_map_pkg;

  // forward crossbar sink index of each device
  typedef enum logic [$clog2(`TILE_NUM_DEV)-1:0]
  {
    e_dev_cfg = 0
    , e_dev_spad = 1
  } dev_id_e;

  // register offsets inside the cfg block
  //   0x004  freeze
  //   0x008  boot pc
  //   0x00c  core id, read only
  //   0x01c  hio mask
  typedef enum logic [11:0]
  {
    e_cfg_freeze = 12'h004
    , e_cfg_boot_npc = 12'h008
    , e_cfg_core_id = 12'h00c
    , e_cfg_hio_mask = 12'h01c
  } cfg_reg_e;

endpackage

/* source/tile_msg_pkg.sv */
`include "tile_params.svh"

package tile_msg_pkg;

  // single-beat memory opcodes
  typedef enum logic
  {
    e_mem_rd = 1'b0
    , e_mem_wr = 1'b1
  } mem_op_e;

  // which request engine issued a message
  typedef logic [$clog2(`TILE_NUM_SRC)-1:0] src_id_t;

  // request from a source towards a device
  typedef struct packed
  {
    mem_op_e                     op;
    logic [`TILE_ADDR_WIDTH-1:0] addr;
    logic [`TILE_DATA_WIDTH-1:0] data;
    src_id_t                     src_id;
  } mem_fwd_s;

  // response from a device, routed back on src_id
  typedef struct packed
  {
    mem_op_e                     op;
    logic [`TILE_ADDR_WIDTH-1:0] addr;
    logic [`TILE_DATA_WIDTH-1:0] data;
    src_id_t                     src_id;
  } mem_rev_s;

endpackage

/* source/tile_params.svh */
`ifndef TILE_PARAMS_SVH
`define TILE_PARAMS_SVH

// request address and data widths
`define TILE_ADDR_WIDTH 16
`define TILE_DATA_WIDTH 32

// front-end and back-end request engines
`define TILE_NUM_SRC 2

// cfg and scratchpad
`define TILE_NUM_DEV 2

// scratchpad geometry, selected by address bits 15:12
`define TILE_SPAD_ELS 16
`define TILE_SPAD_BLOCK 4'h1

// cfg reset values
`define TILE_BOOT_NPC_RESET 16'h0100
`define TILE_CORE_ID 32'h0000_0005

// host I/O enable mask
`define TILE_HIO_WIDTH 8

`endif
